//--- Makefile
# Verilator build and run of the bonded fetch testbench
SRCS := $(filter-out +%,$(shell cat list.f))

obj_dir/Vbonded_fetch_tb: list.f $(SRCS) common/bonded_config.svh
	verilator --binary --timing --top-module bonded_fetch_tb -f list.f

# Assertion errors must not stop the run before the testbench reports
run: obj_dir/Vbonded_fetch_tb
	obj_dir/Vbonded_fetch_tb +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	! grep -q "Simulation failed" sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- common/bonded_config.svh
////////////////////////////////////////////////////////////////////////////
// Sizes shared by the bonded fetch front end. OUT_FIFO_DEPTH must be a
// power of two, and it is also the walker's credit count after reset
////////////////////////////////////////////////////////////////////////////

`ifndef BONDED_CONFIG_SVH
`define BONDED_CONFIG_SVH

// Particle global ID width
`define PID_W 10
// Address width of one topology list, word 0 holds the entry count
`define LIST_AW 6
// One signed fixed-point coordinate
`define COORD_W 16
// Term output FIFO entries
`define OUT_FIFO_DEPTH 4
// Credits the external consumer grants after reset
`define EXT_CREDITS 2

`endif

//--- common/geometry_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Geometry records, x sits in the top bits of each packed record
////////////////////////////////////////////////////////////////////////////

`include "bonded_config.svh"

package geometry_pkg;

	typedef struct packed {
		logic signed [`COORD_W-1:0] x;
		logic signed [`COORD_W-1:0] y;
		logic signed [`COORD_W-1:0] z;
	} pos_t;

	// Position of b minus position of a, wraps in COORD_W
	typedef struct packed {
		logic signed [`COORD_W-1:0] dx;
		logic signed [`COORD_W-1:0] dy;
		logic signed [`COORD_W-1:0] dz;
	} disp_t;

endpackage

//--- common/pair_if.sv
////////////////////////////////////////////////////////////////////////////
// Walker to reader link. The reader never stalls, so valid is only
// allowed while the walker holds a credit
////////////////////////////////////////////////////////////////////////////

interface pair_if import topology_pkg::*; ();

	logic valid;
	pair_t pair;
	// One-cycle pulse, one FIFO slot freed downstream
	logic credit;

	modport walker (
		output valid, pair,
		input credit
	);

	modport reader (
		input valid, pair,
		output credit
	);

endinterface

//--- common/term_if.sv
////////////////////////////////////////////////////////////////////////////
// Reader to output stage link, two cycles behind the pair link
////////////////////////////////////////////////////////////////////////////

interface term_if import topology_pkg::*, geometry_pkg::*; ();

	logic valid;
	pair_t pair;
	disp_t disp;
	// Pulsed when a FIFO entry leaves the chip
	logic credit_return;

	modport reader (
		output valid, pair, disp,
		input credit_return
	);

	modport out_stage (
		input valid, pair, disp,
		output credit_return
	);

endinterface

//--- common/topology_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Topology types for the bonded fetch front end
////////////////////////////////////////////////////////////////////////////

`include "bonded_config.svh"

package topology_pkg;

	// Same encoding as the active force code of the memory controller
	typedef enum logic [1:0] {
		KIND_NONE    = 2'd0,
		KIND_BOND    = 2'd1,
		KIND_ANGLE   = 2'd2,
		KIND_TORSION = 2'd3
	} force_kind_e;

	typedef enum logic [2:0] {
		WALK_IDLE, WALK_COUNTS, WALK_BOND, WALK_ANGLE,
		WALK_TORSION, WALK_DRAIN, WALK_DONE
	} walk_state_e;

	// Memory selected by the load port
	typedef enum logic [1:0] {
		LOAD_BOND, LOAD_ANGLE, LOAD_TORSION, LOAD_POS
	} load_target_e;

	typedef struct packed {
		force_kind_e kind;
		logic [`PID_W-1:0] id_a;
		logic [`PID_W-1:0] id_b;
	} pair_t;

endpackage

//--- fetch/bonded_list_walker.sv
////////////////////////////////////////////////////////////////////////////
// Walks bonds, angles, torsions in turn. One idle cycle after each new
// entry address while the list memory catches up
////////////////////////////////////////////////////////////////////////////

`include "bonded_config.svh"

module bonded_list_walker import topology_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic load_en,
	input  load_target_e load_target,
	input  logic [`PID_W-1:0] load_addr,
	input  logic [63:0] load_data,
	output logic done,
	pair_if.walker pair_out
);

	localparam int CRED_W = $clog2(`OUT_FIFO_DEPTH + 1);

	walk_state_e state;
	walk_state_e next_list;
	force_kind_e cur_kind;
	logic [`LIST_AW-1:0] addr;
	logic [`LIST_AW-1:0] cur_count;
	logic [`LIST_AW-1:0] cnt_bond, cnt_angle, cnt_torsion;
	logic [`LIST_AW-1:0] mem_cnt_bond, mem_cnt_angle, mem_cnt_torsion;
	logic [4*`PID_W-1:0] entry;
	logic [`PID_W-1:0] id_x, id_y;
	logic [1:0] sub;
	logic [CRED_W-1:0] credits;
	logic rd_ok;
	logic last_sub;
	logic fire;

	topology_mem u_mem (
		.clk(clk), .rst(rst),
		.load_en(load_en), .load_target(load_target),
		.load_addr(load_addr), .load_data(load_data),
		.rd_kind(cur_kind), .rd_addr(addr),
		.rd_count_bond(mem_cnt_bond), .rd_count_angle(mem_cnt_angle),
		.rd_count_torsion(mem_cnt_torsion), .rd_entry(entry)
	);

	always_comb
	begin
		cur_kind = KIND_NONE;
		cur_count = '0;
		next_list = WALK_DRAIN;
		case (state)
			WALK_BOND:
			begin
				cur_kind = KIND_BOND;
				cur_count = cnt_bond;
				next_list = WALK_ANGLE;
			end
			WALK_ANGLE:
			begin
				cur_kind = KIND_ANGLE;
				cur_count = cnt_angle;
				next_list = WALK_TORSION;
			end
			WALK_TORSION:
			begin
				cur_kind = KIND_TORSION;
				cur_count = cnt_torsion;
			end
			default: ;
		endcase
	end

	// Pair expansion: angle ab, bc, ca and torsion ab, cd
	always_comb
	begin
		id_x = entry[0 +: `PID_W];
		id_y = entry[`PID_W +: `PID_W];
		last_sub = 1'b1;
		if (state == WALK_ANGLE)
		begin
			last_sub = (sub == 2'd2);
			if (sub == 2'd1)
			begin
				id_x = entry[`PID_W +: `PID_W];
				id_y = entry[2*`PID_W +: `PID_W];
			end
			else if (sub == 2'd2)
			begin
				id_x = entry[2*`PID_W +: `PID_W];
				id_y = entry[0 +: `PID_W];
			end
		end
		else if (state == WALK_TORSION)
		begin
			last_sub = (sub == 2'd1);
			if (sub == 2'd1)
			begin
				id_x = entry[2*`PID_W +: `PID_W];
				id_y = entry[3*`PID_W +: `PID_W];
			end
		end
	end

	assign fire = (cur_kind != KIND_NONE) && (cur_count != '0) && rd_ok && (credits != '0);
	assign pair_out.valid = fire;
	assign pair_out.pair = '{kind: cur_kind, id_a: id_x, id_b: id_y};
	assign done = (state == WALK_DONE);

	always_ff @(posedge clk)
	begin
		if (rst)
			credits <= CRED_W'(`OUT_FIFO_DEPTH);
		else
			credits <= credits - CRED_W'(fire) + CRED_W'(pair_out.credit);
	end

	////////////////////////////////////////////////////////////////////////////
	// Walk FSM
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= WALK_IDLE;
			addr <= '0;
			sub <= '0;
			rd_ok <= 1'b0;
			cnt_bond <= '0;
			cnt_angle <= '0;
			cnt_torsion <= '0;
		end
		else
		begin
			rd_ok <= 1'b1;
			case (state)
				WALK_IDLE, WALK_DONE:
					if (start)
						state <= WALK_COUNTS;
				WALK_COUNTS:
				begin
					cnt_bond <= mem_cnt_bond;
					cnt_angle <= mem_cnt_angle;
					cnt_torsion <= mem_cnt_torsion;
					addr <= `LIST_AW'(1);
					sub <= '0;
					rd_ok <= 1'b0;
					state <= WALK_BOND;
				end
				WALK_BOND, WALK_ANGLE, WALK_TORSION:
				begin
					// Empty list skipped
					if (cur_count == '0)
					begin
						state <= next_list;
						rd_ok <= 1'b0;
					end
					else if (fire && !last_sub)
						sub <= sub + 2'd1;
					else if (fire)
					begin
						sub <= '0;
						rd_ok <= 1'b0;
						if (addr == cur_count)
						begin
							addr <= `LIST_AW'(1);
							state <= next_list;
						end
						else
							addr <= addr + `LIST_AW'(1);
					end
				end
				WALK_DRAIN:
					if (credits == CRED_W'(`OUT_FIFO_DEPTH))
						state <= WALK_DONE;
				default:
					state <= WALK_IDLE;
			endcase
		end
	end

endmodule

//--- fetch/topology_mem.sv
////////////////////////////////////////////////////////////////////////////
// List loads use the low LIST_AW address bits; entry id a is in the low
// bits, then b, c and d. Read data appears one cycle after the address
////////////////////////////////////////////////////////////////////////////

`include "bonded_config.svh"

module topology_mem import topology_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic load_en,
	input  load_target_e load_target,
	input  logic [`PID_W-1:0] load_addr,
	input  logic [63:0] load_data,
	input  force_kind_e rd_kind,
	input  logic [`LIST_AW-1:0] rd_addr,
	output logic [`LIST_AW-1:0] rd_count_bond,
	output logic [`LIST_AW-1:0] rd_count_angle,
	output logic [`LIST_AW-1:0] rd_count_torsion,
	output logic [4*`PID_W-1:0] rd_entry
);

	localparam int ENTRY_W = 4 * `PID_W;
	localparam int WORDS = 1 << `LIST_AW;

	logic [ENTRY_W-1:0] lists [3][WORDS];
	logic [`LIST_AW-1:0] list_addr;
	logic [1:0] rd_sel;
	logic list_wr;

	assign list_addr = load_addr[`LIST_AW-1:0];
	assign list_wr = load_en && (load_target != LOAD_POS);
	// Kind none falls back to the bond list
	assign rd_sel = (rd_kind == KIND_NONE) ? 2'd0 : 2'(rd_kind) - 2'd1;

	always_ff @(posedge clk)
	begin
		if (list_wr)
			lists[2'(load_target)][list_addr] <= load_data[ENTRY_W-1:0];
		rd_entry <= lists[rd_sel][rd_addr];
	end

	// Counts shadowed as word 0 is written
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_count_bond <= '0;
			rd_count_angle <= '0;
			rd_count_torsion <= '0;
		end
		else if (list_wr && list_addr == '0)
		begin
			case (load_target)
				LOAD_BOND: rd_count_bond <= load_data[`LIST_AW-1:0];
				LOAD_ANGLE: rd_count_angle <= load_data[`LIST_AW-1:0];
				LOAD_TORSION: rd_count_torsion <= load_data[`LIST_AW-1:0];
				default: ;
			endcase
		end
	end

endmodule

//--- hdl/bonded_fetch_top.sv
////////////////////////////////////////////////////////////////////////////
// Bonded fetch front end. Load the memories before start; done holds
// until the next start
////////////////////////////////////////////////////////////////////////////

`include "bonded_config.svh"

module bonded_fetch_top import topology_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic load_en,
	input  load_target_e load_target,
	input  logic [`PID_W-1:0] load_addr,
	input  logic [63:0] load_data,
	input  logic start,
	output logic done,
	input  logic out_credit,
	output logic out_valid,
	output force_kind_e out_kind,
	output logic [`PID_W-1:0] out_id_a,
	output logic [`PID_W-1:0] out_id_b,
	output logic signed [`COORD_W-1:0] out_dx,
	output logic signed [`COORD_W-1:0] out_dy,
	output logic signed [`COORD_W-1:0] out_dz
);

	pair_if pair_link ();
	term_if term_link ();

	bonded_list_walker u_walker (
		.clk(clk), .rst(rst), .start(start),
		.load_en(load_en), .load_target(load_target),
		.load_addr(load_addr), .load_data(load_data),
		.done(done), .pair_out(pair_link.walker)
	);

	position_reader u_reader (
		.clk(clk), .rst(rst),
		.load_en(load_en), .load_target(load_target),
		.load_addr(load_addr), .load_data(load_data),
		.pair_in(pair_link.reader), .term_out(term_link.reader)
	);

	term_output u_output (
		.clk(clk), .rst(rst),
		.term_in(term_link.out_stage), .out_credit(out_credit),
		.out_valid(out_valid), .out_kind(out_kind),
		.out_id_a(out_id_a), .out_id_b(out_id_b),
		.out_dx(out_dx), .out_dy(out_dy), .out_dz(out_dz)
	);

endmodule

//--- hdl/position_reader.sv
////////////////////////////////////////////////////////////////////////////
// Positions load as {x, y, z} in load_data[47:0]. Never stalls; the
// walker's credits keep the output FIFO from overflowing
////////////////////////////////////////////////////////////////////////////

`include "bonded_config.svh"

module position_reader import topology_pkg::*, geometry_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic load_en,
	input  load_target_e load_target,
	input  logic [`PID_W-1:0] load_addr,
	input  logic [63:0] load_data,
	pair_if.reader pair_in,
	term_if.reader term_out
);

	pos_t pos_mem [1 << `PID_W];
	pos_t pos_a;
	pos_t pos_b;
	pair_t pair_s1;
	logic valid_s1;

	// Stage 1 reads both particles, stage 2 subtracts
	always_ff @(posedge clk)
	begin
		if (load_en && load_target == LOAD_POS)
			pos_mem[load_addr] <= load_data[$bits(pos_t)-1:0];
		pos_a <= pos_mem[pair_in.pair.id_a];
		pos_b <= pos_mem[pair_in.pair.id_b];
		pair_s1 <= pair_in.pair;
		term_out.pair <= pair_s1;
		term_out.disp.dx <= pos_b.x - pos_a.x;
		term_out.disp.dy <= pos_b.y - pos_a.y;
		term_out.disp.dz <= pos_b.z - pos_a.z;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid_s1 <= 1'b0;
			term_out.valid <= 1'b0;
		end
		else
		begin
			valid_s1 <= pair_in.valid;
			term_out.valid <= valid_s1;
		end
	end

	// Slot freed at the output goes straight back to the walker
	assign pair_in.credit = term_out.credit_return;

endmodule

//--- hdl/term_output.sv
////////////////////////////////////////////////////////////////////////////
// Sends one term per cycle while the FIFO and the external credits are
// both nonzero. Outstanding external credits must stay below 256
////////////////////////////////////////////////////////////////////////////

`include "bonded_config.svh"

module term_output import topology_pkg::*, geometry_pkg::*; (
	input  logic clk,
	input  logic rst,
	term_if.out_stage term_in,
	input  logic out_credit,
	output logic out_valid,
	output force_kind_e out_kind,
	output logic [`PID_W-1:0] out_id_a,
	output logic [`PID_W-1:0] out_id_b,
	output logic signed [`COORD_W-1:0] out_dx,
	output logic signed [`COORD_W-1:0] out_dy,
	output logic signed [`COORD_W-1:0] out_dz
);

	localparam int PTR_W = $clog2(`OUT_FIFO_DEPTH);
	localparam int CNT_W = $clog2(`OUT_FIFO_DEPTH + 1);
	localparam int EXT_W = 8;

	typedef struct packed {
		pair_t pair;
		disp_t disp;
	} term_t;

	term_t fifo [`OUT_FIFO_DEPTH];
	term_t head;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] fill;
	logic [EXT_W-1:0] ext_credits;
	logic send;

	assign send = (fill != '0) && (ext_credits != '0);
	assign term_in.credit_return = send;

	always_ff @(posedge clk)
	begin
		if (term_in.valid)
			fifo[wr_ptr] <= '{pair: term_in.pair, disp: term_in.disp};
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
			ext_credits <= EXT_W'(`EXT_CREDITS);
		end
		else
		begin
			wr_ptr <= wr_ptr + PTR_W'(term_in.valid);
			rd_ptr <= rd_ptr + PTR_W'(send);
			fill <= fill + CNT_W'(term_in.valid) - CNT_W'(send);
			ext_credits <= ext_credits + EXT_W'(out_credit) - EXT_W'(send);
		end
	end

	assign head = fifo[rd_ptr];
	assign out_valid = send;
	assign out_kind = head.pair.kind;
	assign out_id_a = head.pair.id_a;
	assign out_id_b = head.pair.id_b;
	assign out_dx = head.disp.dx;
	assign out_dy = head.disp.dy;
	assign out_dz = head.disp.dz;

endmodule

//--- list.f
+incdir+common
common/topology_pkg.sv
common/geometry_pkg.sv
common/pair_if.sv
common/term_if.sv
fetch/topology_mem.sv
fetch/bonded_list_walker.sv
hdl/position_reader.sv
hdl/term_output.sv
hdl/bonded_fetch_top.sv
tests/bonded_fetch_asserts.sv
tests/bonded_fetch_tb.sv

//--- tests/bonded_fetch_asserts.sv
////////////////////////////////////////////////////////////////////////////
// Bound to bonded_fetch_top. Credits are counted here from the valid and
// credit pulses seen on each link
////////////////////////////////////////////////////////////////////////////

`include "bonded_config.svh"

module bonded_fetch_asserts (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic done,
	input  logic out_valid,
	input  logic out_credit,
	input  logic pair_valid,
	input  logic pair_credit
);

	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;
	// Credits each sender may still use
	int ext_avail;
	int pair_avail;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ext_avail <= `EXT_CREDITS;
			pair_avail <= `OUT_FIFO_DEPTH;
		end
		else
		begin
			ext_avail <= ext_avail + int'(out_credit) - int'(out_valid);
			pair_avail <= pair_avail + int'(pair_credit) - int'(pair_valid);
		end
	end

	// External send needs a granted credit
	out_needs_credit: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> ext_avail > 0)
	else
	begin
		$error("out_valid with no external credit");
		fail_count++;
	end

	pair_needs_credit: assert property (@(posedge clk) disable iff (rst)
		pair_valid |-> pair_avail > 0)
	else
	begin
		$error("pair valid with no walker credit");
		fail_count++;
	end

	// done clears once a new walk starts
	done_clears: assert property (@(posedge clk) disable iff (rst)
		start |=> !done)
	else
	begin
		$error("done still high after start");
		fail_count++;
	end

	quiet_after_reset: assert property (@(posedge clk)
		rst |=> !out_valid && !done)
	else
	begin
		$error("out_valid or done high after reset");
		fail_count++;
	end

endmodule

bind bonded_fetch_top bonded_fetch_asserts u_asserts (
	.clk(clk), .rst(rst), .start(start), .done(done),
	.out_valid(out_valid),
	.out_credit(out_credit),
	.pair_valid(pair_link.valid),
	.pair_credit(pair_link.credit)
);

//--- tests/bonded_fetch_tb.sv
////////////////////////////////////////////////////////////////////////////
// Random topology and positions from a fixed seed. Every output term is
// compared against a model queue built from the expansion rules
////////////////////////////////////////////////////////////////////////////

`include "bonded_config.svh"

module bonded_fetch_tb import topology_pkg::*, geometry_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int PERIOD = 40;
	localparam int NUM_TESTS = 5;
	localparam int NPART = 1 << `PID_W;
	localparam int TERM_W = 2 + 2 * `PID_W + 3 * `COORD_W;

	////////////////////////////////////////////////////////////////////////////
	// Test table: bond, angle and torsion counts, then cycles of withheld credit
	////////////////////////////////////////////////////////////////////////////
	string test_name [NUM_TESTS] = '{"bonds_only", "angles_only", "mixed_lists",
		"backpressure", "all_empty"};
	int list_len [NUM_TESTS][3] = '{'{5, 0, 0}, '{0, 4, 0}, '{3, 2, 4},
		'{4, 3, 3}, '{0, 0, 0}};
	int hold_len [NUM_TESTS] = '{0, 0, 0, 60, 0};

	logic clk = 1'b0;
	logic rst;
	logic load_en;
	load_target_e load_target;
	logic [`PID_W-1:0] load_addr;
	logic [63:0] load_data;
	logic start;
	logic done;
	logic out_credit;
	logic out_valid;
	force_kind_e out_kind;
	logic [`PID_W-1:0] out_id_a;
	logic [`PID_W-1:0] out_id_b;
	logic signed [`COORD_W-1:0] out_dx;
	logic signed [`COORD_W-1:0] out_dy;
	logic signed [`COORD_W-1:0] out_dz;

	pos_t pos_ref [NPART];
	logic [TERM_W-1:0] expect_q [$];
	logic [31:0] rng = 32'hf16f;
	int errors = 0;
	int checks = 0;
	int pending = 0;
	int outstanding = `EXT_CREDITS;
	int hold_left = 0;
	int received = 0;
	string cur_name = "after_reset";

	bonded_fetch_top uut (
		.clk(clk), .rst(rst),
		.load_en(load_en), .load_target(load_target),
		.load_addr(load_addr), .load_data(load_data),
		.start(start), .done(done), .out_credit(out_credit),
		.out_valid(out_valid), .out_kind(out_kind),
		.out_id_a(out_id_a), .out_id_b(out_id_b),
		.out_dx(out_dx), .out_dy(out_dy), .out_dz(out_dz)
	);

	always #(PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Term as {kind, a, b, dx, dy, dz}, displacement is b minus a
	function automatic logic [TERM_W-1:0] make_term(input force_kind_e kind,
		input logic [`PID_W-1:0] a, input logic [`PID_W-1:0] b);
		logic [`COORD_W-1:0] dx;
		logic [`COORD_W-1:0] dy;
		logic [`COORD_W-1:0] dz;
		dx = pos_ref[b].x - pos_ref[a].x;
		dy = pos_ref[b].y - pos_ref[a].y;
		dz = pos_ref[b].z - pos_ref[a].z;
		return {kind, a, b, dx, dy, dz};
	endfunction

	function automatic int term_count(input int t);
		return list_len[t][0] + 3 * list_len[t][1] + 2 * list_len[t][2];
	endfunction

	task automatic check_output();
		logic [TERM_W-1:0] got;
		logic [TERM_W-1:0] want;
		got = {out_kind, out_id_a, out_id_b, out_dx, out_dy, out_dz};
		received++;
		pending++;
		if (outstanding == 0)
		begin
			errors++;
			$display("%s: output sent beyond the granted credits", cur_name);
		end
		outstanding--;
		if (expect_q.size() == 0)
		begin
			errors++;
			$display("%s: output arrived with no term left to expect", cur_name);
		end
		else
		begin
			want = expect_q.pop_front();
			checks++;
			if (got !== want)
			begin
				errors++;
				$display("CHECK FAILED %s: expected %h, actual %h", cur_name, want, got);
			end
		end
	endtask

	// Sample at the falling edge, drive 2 ns after the rising edge
	task automatic next_cycle();
		@(negedge clk);
		if (!rst && out_valid)
			check_output();
		@(posedge clk);
		#2;
		out_credit = 1'b0;
		if (hold_left > 0)
			hold_left--;
		else if (pending > 0)
		begin
			out_credit = 1'b1;
			pending--;
			outstanding++;
		end
	endtask

	task automatic load_word(input load_target_e target, input int addr,
		input logic [63:0] data);
		load_en = 1'b1;
		load_target = target;
		load_addr = `PID_W'(addr);
		load_data = data;
		next_cycle();
		load_en = 1'b0;
	endtask

	task automatic load_positions();
		pos_t p;
		for (int i = 0; i < NPART; i++)
		begin
			rng = xorshift(rng);
			p.x = rng[`COORD_W-1:0];
			p.y = rng[31 -: `COORD_W];
			rng = xorshift(rng);
			p.z = rng[`COORD_W-1:0];
			pos_ref[i] = p;
			load_word(LOAD_POS, i, {16'd0, p});
		end
	endtask

	task automatic check_idle_after_reset();
		int errs_before;
		errs_before = errors;
		for (int c = 0; c < 4; c++)
		begin
			next_cycle();
			checks++;
			if (out_valid !== 1'b0 || done !== 1'b0)
			begin
				errors++;
				$display("CHECK FAILED after_reset: expected %b, actual %b",
					2'b00, {out_valid, done});
			end
		end
		$display("after_reset: %s", errors == errs_before ? "ok" : "errors");
	endtask

	task automatic run_test(input int idx);
		int errs_before;
		logic [`PID_W-1:0] id [4];
		errs_before = errors;
		cur_name = test_name[idx];
		received = 0;
		for (int k = 0; k < 3; k++)
		begin
			load_word(load_target_e'(k), 0, 64'(list_len[idx][k]));
			for (int e = 1; e <= list_len[idx][k]; e++)
			begin
				for (int j = 0; j < 4; j++)
				begin
					rng = xorshift(rng);
					id[j] = rng[`PID_W-1:0];
				end
				load_word(load_target_e'(k), e, {24'd0, id[3], id[2], id[1], id[0]});
				case (k)
					0:
						expect_q.push_back(make_term(KIND_BOND, id[0], id[1]));
					1:
					begin
						expect_q.push_back(make_term(KIND_ANGLE, id[0], id[1]));
						expect_q.push_back(make_term(KIND_ANGLE, id[1], id[2]));
						expect_q.push_back(make_term(KIND_ANGLE, id[2], id[0]));
					end
					default:
					begin
						expect_q.push_back(make_term(KIND_TORSION, id[0], id[1]));
						expect_q.push_back(make_term(KIND_TORSION, id[2], id[3]));
					end
				endcase
			end
		end
		hold_left = hold_len[idx];
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		next_cycle();
		checks++;
		if (done !== 1'b0)
		begin
			errors++;
			$display("CHECK FAILED %s: expected done 0, actual %b", cur_name, done);
		end
		while (done !== 1'b1)
			next_cycle();
		checks++;
		if (expect_q.size() != 0)
		begin
			errors++;
			$display("%s: done rose with %0d terms missing", cur_name, expect_q.size());
			expect_q.delete();
		end
		// done holds until the next start
		for (int c = 0; c < 3; c++)
		begin
			next_cycle();
			checks++;
			if (done !== 1'b1)
			begin
				errors++;
				$display("CHECK FAILED %s: expected done 1, actual %b", cur_name, done);
			end
		end
		while (pending > 0)
			next_cycle();
		$display("%s: %0d terms, %s", cur_name, received,
			errors == errs_before ? "ok" : "errors");
	endtask

	initial
	begin
		rst = 1'b1;
		load_en = 1'b0;
		load_target = LOAD_BOND;
		load_addr = '0;
		load_data = '0;
		start = 1'b0;
		out_credit = 1'b0;
		repeat (5)
			next_cycle();
		rst = 1'b0;
		check_idle_after_reset();
		load_positions();
		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t);
		errors += uut.u_asserts.fail_count;
		$display("%0d tests, %0d checks, %0d errors", NUM_TESTS + 1, checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// Watchdog sized from the table: loads, 40 cycles per term, hold time
	initial
	begin
		int budget;
		budget = NPART + 100;
		for (int t = 0; t < NUM_TESTS; t++)
			budget += 40 * term_count(t) + list_len[t][0] + list_len[t][1]
				+ list_len[t][2] + hold_len[t] + 40;
		#(budget * PERIOD);
		$display("Watchdog: run did not finish within %0d cycles", budget);
		$display("Simulation failed");
		$finish;
	end

endmodule
